//--- src/pq_pkg.sv
package pq_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Queue geometry
  ///////////////////////////////////////////////////////////////////////

  // Key width in bits
  localparam int KEY_W = 32;

  // Number of entries in the queue
  localparam int DEPTH = 16;

  // Entry address width
  localparam int ADDR_W = $clog2(DEPTH);

  // Occupancy count, wide enough to reach DEPTH
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Largest possible key, carried down during a dequeue
  localparam logic [KEY_W-1:0] FILL_KEY = {KEY_W{1'b1}};

  ///////////////////////////////////////////////////////////////////////
  // Carry register source select
  ///////////////////////////////////////////////////////////////////////

  // Shared between the control FSM and the swap datapath
  typedef enum logic [1:0]
  {
    LOAD_HOLD  = 2'b00,
    LOAD_INPUT = 2'b01,
    LOAD_ENTRY = 2'b10,
    LOAD_FILL  = 2'b11
  } pq_load_sel_t;

endpackage

//--- src/pq_entry_ram.sv
`timescale 1ns/1ps

// Single-port key store with a registered read port
module pq_entry_ram import pq_pkg::*;
(
  input  logic              clk,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  logic [KEY_W-1:0]  wr_data,
  output logic [KEY_W-1:0]  rd_data
);

  logic [KEY_W-1:0] mem [DEPTH];

  // Write port
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[addr] <= wr_data;
    end
  end

  // Read port returns the old entry on a write cycle,
  // so a swap needs only one edge
  always_ff @(posedge clk)
  begin
    rd_data <= mem[addr];
  end

endmodule

//--- src/pq_swap_datapath.sv
`timescale 1ns/1ps

// Carry register, its source mux and the key comparator
module pq_swap_datapath import pq_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  pq_load_sel_t     load_sel,
  input  logic [KEY_W-1:0] key_in,
  input  logic [KEY_W-1:0] rd_data,
  output logic [KEY_W-1:0] carry_key,
  output logic             key_less
);

  logic [KEY_W-1:0] carry_next;

  ///////////////////////////////////////////////////////////////////////
  // Source select
  ///////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (load_sel)
      LOAD_INPUT:
      begin
        carry_next = key_in;
      end
      LOAD_ENTRY:
      begin
        // Take the displaced entry on a swap
        carry_next = rd_data;
      end
      LOAD_FILL:
      begin
        carry_next = FILL_KEY;
      end
      default:
      begin
        carry_next = carry_key;
      end
    endcase
  end

  ///////////////////////////////////////////////////////////////////////
  // Carry register
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      carry_key <= '0;
    end
    else
    begin
      carry_key <= carry_next;
    end
  end

  // Strictly less, so equal keys keep their place
  assign key_less = (carry_key < rd_data);

endmodule

//--- src/pq_control_fsm.sv
`timescale 1ns/1ps

// Sequencer for the insert and remove walks
module pq_control_fsm import pq_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              enq,
  input  logic              deq,
  input  logic              key_less,
  output pq_load_sel_t      load_sel,
  output logic [ADDR_W-1:0] mem_addr,
  output logic              mem_we,
  output logic              out_valid,
  output logic              busy,
  output logic              full,
  output logic              empty,
  output logic [CNT_W-1:0]  count
);

  typedef enum logic [3:0]
  {
    IDLE        = 4'd0,
    ENQ_LOAD    = 4'd1,
    ENQ_READ    = 4'd2,
    ENQ_COMPARE = 4'd3,
    ENQ_PLACE   = 4'd4,
    DEQ_LOAD    = 4'd5,
    DEQ_READ    = 4'd6,
    DEQ_SWAP    = 4'd7,
    DEQ_OUTPUT  = 4'd8
  } state_t;

  state_t state;
  state_t next_state;

  logic [ADDR_W-1:0] idx;
  logic [ADDR_W-1:0] last_idx;
  logic              enq_go;
  logic              deq_go;

  ///////////////////////////////////////////////////////////////////////
  // Request acceptance and status
  ///////////////////////////////////////////////////////////////////////

  // Enqueue wins when both strobes arrive together
  assign enq_go = (state == IDLE) && !busy && enq && !full;
  assign deq_go = (state == IDLE) && !busy && deq && !empty && !enq_go;

  // Highest occupied index
  assign last_idx = ADDR_W'(count - CNT_W'(1));

  assign full      = (count == CNT_W'(DEPTH));
  assign empty     = (count == '0);
  assign out_valid = (state == DEQ_OUTPUT);

  ///////////////////////////////////////////////////////////////////////
  // Next state and datapath controls
  ///////////////////////////////////////////////////////////////////////

  always_comb
  begin
    next_state = state;
    load_sel   = LOAD_HOLD;
    mem_we     = 1'b0;
    mem_addr   = idx;
    case (state)
      IDLE:
      begin
        if (enq_go)
        begin
          // key_in is captured on the accepting edge
          load_sel   = LOAD_INPUT;
          next_state = ENQ_LOAD;
        end
        else if (deq_go)
        begin
          next_state = DEQ_LOAD;
        end
      end
      ENQ_LOAD:
      begin
        // Empty queue goes straight to slot 0
        if (empty)
        begin
          next_state = ENQ_PLACE;
        end
        else
        begin
          next_state = ENQ_READ;
        end
      end
      ENQ_READ:
      begin
        next_state = ENQ_COMPARE;
      end
      ENQ_COMPARE:
      begin
        if (key_less)
        begin
          mem_we   = 1'b1;
          load_sel = LOAD_ENTRY;
        end
        if (idx == last_idx)
        begin
          next_state = ENQ_PLACE;
        end
        else
        begin
          next_state = ENQ_READ;
        end
      end
      ENQ_PLACE:
      begin
        // First free slot sits right after the occupied ones
        mem_we     = 1'b1;
        mem_addr   = count[ADDR_W-1:0];
        next_state = IDLE;
      end
      DEQ_LOAD:
      begin
        load_sel   = LOAD_FILL;
        next_state = DEQ_READ;
      end
      DEQ_READ:
      begin
        next_state = DEQ_SWAP;
      end
      DEQ_SWAP:
      begin
        // Every step of a dequeue swaps
        mem_we   = 1'b1;
        load_sel = LOAD_ENTRY;
        if (idx == '0)
        begin
          next_state = DEQ_OUTPUT;
        end
        else
        begin
          next_state = DEQ_READ;
        end
      end
      DEQ_OUTPUT:
      begin
        next_state = IDLE;
      end
      default:
      begin
        next_state = IDLE;
      end
    endcase
  end

  ///////////////////////////////////////////////////////////////////////
  // State, index, count and busy registers
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
      idx   <= '0;
      count <= '0;
      busy  <= 1'b0;
    end
    else
    begin
      state <= next_state;

      // Busy holds one cycle past the return to IDLE
      if (enq_go || deq_go)
      begin
        busy <= 1'b1;
      end
      else if (state == IDLE)
      begin
        busy <= 1'b0;
      end

      case (state)
        IDLE:
        begin
          if (enq_go)
          begin
            idx <= '0;
          end
          else if (deq_go)
          begin
            idx <= last_idx;
          end
        end
        ENQ_COMPARE:
        begin
          if (idx != last_idx)
          begin
            idx <= idx + ADDR_W'(1);
          end
        end
        ENQ_PLACE:
        begin
          count <= count + CNT_W'(1);
        end
        DEQ_SWAP:
        begin
          if (idx != '0)
          begin
            idx <= idx - ADDR_W'(1);
          end
        end
        DEQ_OUTPUT:
        begin
          count <= count - CNT_W'(1);
        end
        default:
        begin
          idx <= idx;
        end
      endcase
    end
  end

endmodule

//--- src/pq_top.sv
`timescale 1ns/1ps

// Sorted priority queue of DEPTH keys
module pq_top import pq_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             enq,
  input  logic [KEY_W-1:0] key_in,
  input  logic             deq,
  output logic [KEY_W-1:0] key_out,
  output logic             out_valid,
  output logic             busy,
  output logic             full,
  output logic             empty,
  output logic [CNT_W-1:0] count
);

  pq_load_sel_t      load_sel;
  logic              key_less;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_we;
  logic [KEY_W-1:0]  rd_data;
  logic [KEY_W-1:0]  carry_key;

  // Carried key doubles as the dequeue result
  assign key_out = carry_key;

  ///////////////////////////////////////////////////////////////////////
  // Control, datapath and entry store
  ///////////////////////////////////////////////////////////////////////

  pq_control_fsm i_pq_control_fsm
  (
    .clk       (clk),
    .rst       (rst),
    .enq       (enq),
    .deq       (deq),
    .key_less  (key_less),
    .load_sel  (load_sel),
    .mem_addr  (mem_addr),
    .mem_we    (mem_we),
    .out_valid (out_valid),
    .busy      (busy),
    .full      (full),
    .empty     (empty),
    .count     (count)
  );

  pq_swap_datapath i_pq_swap_datapath
  (
    .clk       (clk),
    .rst       (rst),
    .load_sel  (load_sel),
    .key_in    (key_in),
    .rd_data   (rd_data),
    .carry_key (carry_key),
    .key_less  (key_less)
  );

  // Memory always stores the carried key
  pq_entry_ram i_pq_entry_ram
  (
    .clk     (clk),
    .we      (mem_we),
    .addr    (mem_addr),
    .wr_data (carry_key),
    .rd_data (rd_data)
  );

endmodule

//--- verification/pq_clock_gen.sv
`timescale 1ns/1ps

// Free-running testbench clock, 10 ns period
module pq_clock_gen
(
  output logic clk
);

  localparam int HALF_PERIOD = 5;

  initial
  begin
    clk = 1'b0;
  end

  always #HALF_PERIOD clk = ~clk;

endmodule

//--- verification/pq_tb.sv
`timescale 1ns/1ps

module pq_tb import pq_pkg::*;
();

  // About 70 operations of at most 37 cycles each, plus idle checks and margin
  localparam int MAX_CYCLES = 6000;

  logic             clk;
  logic             rst;
  logic             enq;
  logic [KEY_W-1:0] key_in;
  logic             deq;
  logic [KEY_W-1:0] key_out;
  logic             out_valid;
  logic             busy;
  logic             full;
  logic             empty;
  logic [CNT_W-1:0] count;

  // Reference contents, kept in ascending order
  logic [KEY_W-1:0] model[$];

  integer seed = 822;
  int     checks = 0;
  int     errors = 0;
  int     cycle_count = 0;

  pq_clock_gen i_pq_clock_gen
  (
    .clk (clk)
  );

  pq_top i_pq_top
  (
    .clk       (clk),
    .rst       (rst),
    .enq       (enq),
    .key_in    (key_in),
    .deq       (deq),
    .key_out   (key_out),
    .out_valid (out_valid),
    .busy      (busy),
    .full      (full),
    .empty     (empty),
    .count     (count)
  );

  ////////////////////////////////////////////////////////////////////////
  // Run limit
  ////////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Timeout: run exceeded %0d cycles, the DUT did not finish", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Reference model and checking helpers
  ////////////////////////////////////////////////////////////////////////

  // Equal keys go behind the ones already stored
  task automatic model_insert(input logic [KEY_W-1:0] key);
    int pos;
    pos = 0;
    while (pos < model.size() && model[pos] <= key)
    begin
      pos++;
    end
    model.insert(pos, key);
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("CHECK FAILED %s: %s expected 'h%0h actual 'h%0h",
               test, what, expected, actual);
    end
  endtask

  task automatic check_status(input string test);
    check_value(test, "count", 32'(model.size()), 32'(count));
    check_value(test, "full", (model.size() == DEPTH) ? 32'd1 : 32'd0, 32'(full));
    check_value(test, "empty", (model.size() == 0) ? 32'd1 : 32'd0, 32'(empty));
  endtask

  // Called on a falling edge, returns on the falling edge where busy is low
  task automatic wait_not_busy(output int cycles, output int pulses,
                               output logic [KEY_W-1:0] seen_key);
    cycles   = 0;
    pulses   = 0;
    seen_key = '0;
    while (busy)
    begin
      if (out_valid)
      begin
        pulses++;
        seen_key = key_out;
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Operations
  ////////////////////////////////////////////////////////////////////////

  task automatic enqueue_key(input string test, input logic [KEY_W-1:0] key,
                             input logic with_deq);
    int               n;
    int               cycles;
    int               pulses;
    logic [KEY_W-1:0] seen;
    n      = model.size();
    enq    = 1'b1;
    deq    = with_deq;
    key_in = key;
    @(negedge clk);
    enq = 1'b0;
    deq = 1'b0;
    wait_not_busy(cycles, pulses, seen);
    model_insert(key);
    check_value(test, "enqueue busy cycles", 32'(2 * n + 3), 32'(cycles));
    check_value(test, "out_valid pulses on enqueue", 32'd0, 32'(pulses));
    check_status(test);
  endtask

  task automatic dequeue_min(input string test);
    int               n;
    int               cycles;
    int               pulses;
    logic [KEY_W-1:0] seen;
    logic [KEY_W-1:0] expected;
    n        = model.size();
    expected = model.pop_front();
    deq      = 1'b1;
    @(negedge clk);
    deq = 1'b0;
    wait_not_busy(cycles, pulses, seen);
    if (pulses != 1)
    begin
      errors++;
      $display("%s: dequeue gave %0d out_valid pulses instead of one", test, pulses);
    end
    else
    begin
      check_value(test, "dequeued key", expected, seen);
    end
    check_value(test, "dequeue busy cycles", 32'(2 * n + 3), 32'(cycles));
    check_status(test);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    check_status("reset_state");
    check_value("reset_state", "busy", 32'd0, 32'(busy));
    check_value("reset_state", "out_valid", 32'd0, 32'(out_valid));
  endtask

  task automatic test_ascending_order();
    logic [KEY_W-1:0] key;
    for (int i = 0; i < 8; i++)
    begin
      key = $random(seed);
      enqueue_key("ascending_order", key, 1'b0);
    end
    for (int i = 0; i < 8; i++)
    begin
      dequeue_min("ascending_order");
    end
  endtask

  task automatic test_duplicates_extremes();
    enqueue_key("duplicates_extremes", 32'd5, 1'b0);
    enqueue_key("duplicates_extremes", 32'd0, 1'b0);
    enqueue_key("duplicates_extremes", 32'hFFFF_FFFE, 1'b0);
    enqueue_key("duplicates_extremes", 32'd5, 1'b0);
    dequeue_min("duplicates_extremes");
    enqueue_key("duplicates_extremes", 32'd5, 1'b0);
    enqueue_key("duplicates_extremes", 32'hFFFF_FFFE, 1'b0);
    dequeue_min("duplicates_extremes");
    enqueue_key("duplicates_extremes", 32'd0, 1'b0);
    dequeue_min("duplicates_extremes");
    dequeue_min("duplicates_extremes");
    // Drain what is left, the two near-max keys come out last
    while (model.size() > 0)
    begin
      dequeue_min("duplicates_extremes");
    end
  endtask

  task automatic test_full_behaviour();
    logic [KEY_W-1:0] key;
    while (model.size() < DEPTH)
    begin
      key = $random(seed);
      enqueue_key("full_behaviour", key, 1'b0);
    end
    // Enqueue on a full queue must be dropped
    enq    = 1'b1;
    key_in = 32'd1;
    @(negedge clk);
    enq = 1'b0;
    repeat (3)
    begin
      check_value("full_behaviour", "busy after ignored enqueue", 32'd0, 32'(busy));
      @(negedge clk);
    end
    check_status("full_behaviour");
    dequeue_min("full_behaviour");
  endtask

  task automatic test_empty_behaviour();
    int pulses;
    while (model.size() > 0)
    begin
      dequeue_min("empty_behaviour");
    end
    pulses = 0;
    deq    = 1'b1;
    @(negedge clk);
    deq = 1'b0;
    repeat (40)
    begin
      if (out_valid)
      begin
        pulses++;
      end
      @(negedge clk);
    end
    if (pulses != 0)
    begin
      errors++;
      $display("empty_behaviour: dequeue on an empty queue produced out_valid");
    end
    check_value("empty_behaviour", "busy after empty dequeue", 32'd0, 32'(busy));
    check_status("empty_behaviour");
  endtask

  task automatic test_simultaneous();
    enqueue_key("simultaneous", 32'd300, 1'b0);
    enqueue_key("simultaneous", 32'd100, 1'b0);
    enqueue_key("simultaneous", 32'd200, 1'b0);
    // Both strobes together, only the enqueue runs
    enqueue_key("simultaneous", 32'd150, 1'b1);
    while (model.size() > 0)
    begin
      dequeue_min("simultaneous");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////

  initial
  begin
    rst    = 1'b1;
    enq    = 1'b0;
    deq    = 1'b0;
    key_in = '0;
    repeat (5)
    begin
      @(negedge clk);
    end
    rst = 1'b0;
    @(negedge clk);

    test_reset_state();
    test_ascending_order();
    test_duplicates_extremes();
    test_full_behaviour();
    test_empty_behaviour();
    test_simultaneous();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- list.f
src/pq_pkg.sv
src/pq_entry_ram.sv
src/pq_swap_datapath.sv
src/pq_control_fsm.sv
src/pq_top.sv
verification/pq_clock_gen.sv
verification/pq_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the priority queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module pq_tb -Mdir obj_dir -o pq_sim -f list.f \
  || { echo "Verilator build error"; exit 1; }
./obj_dir/pq_sim > sim.log 2>&1 \
  || { cat sim.log; echo "Simulator exited with an error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || { echo "No result line in sim.log"; exit 1; }
exit 0
